/* sim.f */
source/fb_geom_pkg.sv
source/fb_types_pkg.sv
source/mem_lane.sv
source/multimem.sv
source/bitplane_scanner.sv
source/framebuffer_top.sv
test/tb_clock_gen.sv
test/tb_framebuffer.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the framebuffer testbench with Verilator, result from the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module tb_framebuffer \
    -Mdir obj_dir -o sim_tb > build.log 2>&1 \
    && ./obj_dir/sim_tb > sim.log 2>&1
grep -q "Simulation PASSED" sim.log 2>/dev/null && echo "run passed" \
    || { echo "run failed, see build.log and sim.log"; exit 1; }

/* test/tb_framebuffer.sv */
/*
 * framebuffer testbench
 * directed tests for reset, scan order, lane isolation, random fill and
 * restart while busy, checked against a shadow copy of the lane RAMs
 */
`timescale 1ns/1ns

module tb_framebuffer;
    import fb_geom_pkg::*;
    import fb_types_pkg::*;

    localparam int DEPTH = 1 << BODY_BITS;
    localparam int FRAME_LEN = (1 << PLANE_BITS) * DEPTH;
    // twice the length of two full fills and five frames with their idle gaps
    localparam int TIMEOUT_CYCLES = 2 * (2 * LANES * DEPTH + 5 * (FRAME_LEN + 8) + 200);

    logic                  ClockA;
    logic                  arst_n;
    logic                  wr_en;
    mem_write_addr_t       wr_addr;
    logic [BYTE_W-1:0]     wr_data;
    logic                  scan_start;
    logic                  pixel_valid;
    mem_read_addr_t        pixel_addr;
    logic [PLANE_BITS-1:0] pixel_plane;
    rgb_bits_t             pixel_rgb;
    logic                  frame_done;
    logic                  scan_busy;

    // shadow of every lane RAM
    logic [BYTE_W-1:0] shadow [LANES][DEPTH];
    // rgb results of the last frame indexed by plane * 64 + addr
    rgb_bits_t seen [FRAME_LEN];
    rgb_bits_t baseline [FRAME_LEN];
    int cycle_count = 0;

    tb_clock_gen clk_i (
        .ClockA(ClockA),
        .arst_n(arst_n)
    );

    framebuffer_top #(
        .ADDR_BITS(BODY_BITS),
        .DW       (BYTE_W)
    ) dut_i (
        .ClockA     (ClockA),
        .arst_n     (arst_n),
        .wr_en      (wr_en),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data),
        .scan_start (scan_start),
        .pixel_valid(pixel_valid),
        .pixel_addr (pixel_addr),
        .pixel_plane(pixel_plane),
        .pixel_rgb  (pixel_rgb),
        .frame_done (frame_done),
        .scan_busy  (scan_busy)
    );

    // hard stop if a test never returns
    always @(posedge ClockA) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Simulation FAILED");
            $fatal(1, "timeout");
        end
    end

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] got);
        assert (got === exp) else begin
            $display("Fail %s exp=%h got=%h", name, exp, got);
            $display("Simulation FAILED");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    // plane bit of the red, green and blue byte of each panel with panel 0 lowest
    function automatic rgb_bits_t expected_rgb(input int addr, input int plane);
        rgb_bits_t bits;
        for (int p = 0; p < PANELS; p++) begin
            bits[3*p]     = shadow[4*p][addr][plane];
            bits[3*p + 1] = shadow[4*p + 1][addr][plane];
            bits[3*p + 2] = shadow[4*p + 2][addr][plane];
        end
        return bits;
    endfunction

    // lane is panel * 4 + colour and addr is {row, col}
    task automatic write_byte(input int lane, input int addr, input logic [7:0] data);
        @(posedge ClockA);
        wr_en   <= 1'b1;
        wr_addr <= {2'(lane >> 2), 6'(addr), 2'(lane)};
        wr_data <= data;
        shadow[lane][addr] = data;
    endtask

    // quiet bus for n cycles
    task automatic wait_cycles(input int n);
        repeat (n) begin
            @(posedge ClockA);
            wr_en      <= 1'b0;
            scan_start <= 1'b0;
        end
    endtask

    // one full scan with every result checked
    // a negative restart_at gives no second start
    task automatic run_frame_check(input int restart_at);
        int k;
        int idx;
        @(posedge ClockA);
        wr_en      <= 1'b0;
        scan_start <= 1'b1;
        // start taken on the next edge followed by one issue cycle and two read cycles
        for (k = 1; k <= 3; k++) begin
            @(posedge ClockA);
            scan_start <= 1'b0;
            @(negedge ClockA);
            if (k < 3) begin
                check_value("pixel_valid", 32'(0), 32'(pixel_valid));
                check_value("scan_busy", 32'(1), 32'(scan_busy));
            end
        end
        // plane outer and address inner, one result per cycle
        for (idx = 0; idx < FRAME_LEN; idx++) begin
            check_value("pixel_valid", 32'(1), 32'(pixel_valid));
            check_value("scan_busy", 32'(1), 32'(scan_busy));
            check_value("pixel_plane", 32'(idx / DEPTH), 32'(pixel_plane));
            check_value("pixel_addr", 32'(idx % DEPTH), 32'(pixel_addr));
            check_value("pixel_rgb", 32'(expected_rgb(idx % DEPTH, idx / DEPTH)),
                        32'(pixel_rgb));
            check_value("frame_done", 32'(idx == FRAME_LEN - 1), 32'(frame_done));
            seen[idx] = pixel_rgb;
            @(posedge ClockA);
            scan_start <= (idx == restart_at);
            @(negedge ClockA);
        end
        // drained with no second frame following
        for (k = 0; k < 6; k++) begin
            check_value("pixel_valid", 32'(0), 32'(pixel_valid));
            check_value("frame_done", 32'(0), 32'(frame_done));
            check_value("scan_busy", 32'(0), 32'(scan_busy));
            @(posedge ClockA);
            scan_start <= 1'b0;
            @(negedge ClockA);
        end
    endtask

    task automatic idle_after_reset();
        // negedges 1..7 fall inside the 8-cycle reset
        repeat (7) begin
            @(negedge ClockA);
            check_value("pixel_valid", 32'(0), 32'(pixel_valid));
            check_value("frame_done", 32'(0), 32'(frame_done));
            check_value("scan_busy", 32'(0), 32'(scan_busy));
        end
        wait (arst_n === 1'b1);
        wait_cycles(3);
        @(negedge ClockA);
        check_value("pixel_valid", 32'(0), 32'(pixel_valid));
        check_value("frame_done", 32'(0), 32'(frame_done));
        check_value("scan_busy", 32'(0), 32'(scan_busy));
    endtask

    // known contents everywhere built from lane and body address
    task automatic scan_known_pattern();
        for (int lane = 0; lane < LANES; lane++) begin
            for (int addr = 0; addr < DEPTH; addr++) begin
                write_byte(lane, addr, 8'((lane << 4) ^ (addr * 3) ^ 8'h5a));
            end
        end
        wait_cycles(3);
        run_frame_check(-1);
    endtask

    task automatic isolate_one_lane();
        int idx;
        for (int lane = 0; lane < LANES; lane++) begin
            write_byte(lane, 27, 8'(lane * 17) ^ 8'h3c);
        end
        wait_cycles(3);
        run_frame_check(-1);
        baseline = seen;
        // panel 2 green is lane 9
        // inverting the byte flips its bit in every plane
        write_byte(9, 27, ~shadow[9][27]);
        wait_cycles(3);
        run_frame_check(-1);
        for (int plane = 0; plane < (1 << PLANE_BITS); plane++) begin
            for (int addr = 26; addr <= 28; addr++) begin
                idx = plane * DEPTH + addr;
                check_value("pixel_rgb change", (addr == 27) ? 32'h080 : 32'h0,
                            32'(seen[idx] ^ baseline[idx]));
            end
        end
    endtask

    // spare lanes get random bytes too and the scan must ignore them
    task automatic fill_random_frame();
        for (int lane = 0; lane < LANES; lane++) begin
            for (int addr = 0; addr < DEPTH; addr++) begin
                write_byte(lane, addr, 8'($urandom));
            end
        end
        wait_cycles(3);
        run_frame_check(-1);
    endtask

    // second start pulse lands in the middle of plane 3
    task automatic restart_while_busy();
        run_frame_check(200);
    endtask

    initial begin
        wr_en      = 1'b0;
        wr_addr    = '0;
        wr_data    = '0;
        scan_start = 1'b0;
        void'($urandom(32'h5a6129a1));
        idle_after_reset();
        scan_known_pattern();
        isolate_one_lane();
        fill_random_frame();
        restart_while_busy();
        $display("Simulation PASSED");
        $finish;
    end

endmodule

/* test/tb_clock_gen.sv */
/*
 * testbench clock and reset
 * 40 ns ClockA, arst_n held low for the first 8 rising edges
 */
`timescale 1ns/1ns

module tb_clock_gen #(
    parameter int unsigned HALF_PERIOD = 20,
    parameter int unsigned RESET_CYCLES = 8
) (
    output logic ClockA,
    output logic arst_n
);

    initial begin
        ClockA = 1'b0;
        forever #HALF_PERIOD ClockA = ~ClockA;
    end

    // release lands just after a rising edge
    initial begin
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge ClockA);
        arst_n <= 1'b1;
    end

endmodule

/* source/framebuffer_top.sv */
/*
 * LED framebuffer top level
 * host byte writes into the banked RAM, bit-plane scan reads out
 */
`timescale 1ns/1ns

module framebuffer_top #(
    parameter int unsigned ADDR_BITS = fb_geom_pkg::BODY_BITS,
    parameter int unsigned DW = fb_geom_pkg::BYTE_W
) (
    input  logic                               ClockA,
    input  logic                               arst_n,
    input  logic                               wr_en,
    input  fb_types_pkg::mem_write_addr_t      wr_addr,
    input  logic [DW-1:0]                      wr_data,
    input  logic                               scan_start,
    output logic                               pixel_valid,
    output fb_types_pkg::mem_read_addr_t       pixel_addr,
    output logic [fb_geom_pkg::PLANE_BITS-1:0] pixel_plane,
    output fb_types_pkg::rgb_bits_t            pixel_rgb,
    output logic                               frame_done,
    output logic                               scan_busy
);
    import fb_types_pkg::*;

    // scanner to RAM read port
    logic           rd_en;
    mem_read_addr_t rd_addr;
    mem_read_data_u rd_data;

    multimem #(
        .ADDR_BITS(ADDR_BITS),
        .DW       (DW)
    ) u_multimem (
        .ClockA (ClockA),
        .arst_n (arst_n),
        .wr_en  (wr_en),
        .wr_addr(wr_addr),
        .wr_data(wr_data),
        .rd_en  (rd_en),
        .rd_addr(rd_addr),
        .rd_data(rd_data)
    );

    bitplane_scanner u_scanner (
        .ClockA     (ClockA),
        .arst_n     (arst_n),
        .scan_start (scan_start),
        .rd_en      (rd_en),
        .rd_addr    (rd_addr),
        .rd_data    (rd_data),
        .pixel_valid(pixel_valid),
        .pixel_addr (pixel_addr),
        .pixel_plane(pixel_plane),
        .pixel_rgb  (pixel_rgb),
        .frame_done (frame_done),
        .scan_busy  (scan_busy)
    );

endmodule

/* source/bitplane_scanner.sv */
/*
 * bit-plane scanner
 * walks planes (outer) and body addresses (inner), one read per cycle,
 * and slices the returned word into per-panel rgb plane bits
 */
`timescale 1ns/1ns

module bitplane_scanner (
    input  logic                                ClockA,
    input  logic                                arst_n,
    input  logic                                scan_start,
    output logic                                rd_en,
    output fb_types_pkg::mem_read_addr_t        rd_addr,
    input  fb_types_pkg::mem_read_data_u        rd_data,
    output logic                                pixel_valid,
    output fb_types_pkg::mem_read_addr_t        pixel_addr,
    output logic [fb_geom_pkg::PLANE_BITS-1:0]  pixel_plane,
    output fb_types_pkg::rgb_bits_t             pixel_rgb,
    output logic                                frame_done,
    output logic                                scan_busy
);
    import fb_geom_pkg::*;
    import fb_types_pkg::*;

    // issue side counters
    logic                  busy_q;
    logic [PLANE_BITS-1:0] plane_q;
    mem_read_addr_t        addr_q;
    logic                  last_w;

    // side pipeline, stage 1 (stage 2 is the pixel outputs)
    logic                  s1_valid;
    logic                  s1_last;
    mem_read_addr_t        s1_addr;
    logic [PLANE_BITS-1:0] s1_plane;

    // final read of the frame: top plane, top address
    assign last_w = (plane_q == '1) && (addr_q == '1);

    always_ff @(posedge ClockA or negedge arst_n) begin
        if (!arst_n) begin
            busy_q  <= 1'b0;
            plane_q <= '0;
            addr_q  <= '0;
        end else if (busy_q) begin
            // address wraps into the next plane
            {plane_q, addr_q} <= {plane_q, addr_q} + 1'b1;
            if (last_w) begin
                busy_q <= 1'b0;
            end
        end else if (scan_start && !scan_busy) begin
            // start ignored until the previous frame has drained
            busy_q  <= 1'b1;
            plane_q <= '0;
            addr_q  <= '0;
        end
    end

    // a read goes out on every busy cycle
    assign rd_en   = busy_q;
    assign rd_addr = addr_q;

    // valid and last flags, two stages to match the RAM read
    always_ff @(posedge ClockA or negedge arst_n) begin
        if (!arst_n) begin
            s1_valid    <= 1'b0;
            s1_last     <= 1'b0;
            pixel_valid <= 1'b0;
            frame_done  <= 1'b0;
        end else begin
            s1_valid    <= rd_en;
            s1_last     <= rd_en && last_w;
            pixel_valid <= s1_valid;
            frame_done  <= s1_last;
        end
    end

    // address and plane ride along
    always_ff @(posedge ClockA) begin
        s1_addr     <= addr_q;
        s1_plane    <= plane_q;
        pixel_addr  <= s1_addr;
        pixel_plane <= s1_plane;
    end

    // busy until the last result has left
    assign scan_busy = busy_q || s1_valid || pixel_valid;

    // pick the current plane bit out of each panel's colour bytes
    // spare byte is never shown
    always_comb begin
        for (int p = 0; p < PANELS; p++) begin
            pixel_rgb[3*p]     = rd_data.panel[p].red[pixel_plane];
            pixel_rgb[3*p + 1] = rd_data.panel[p].green[pixel_plane];
            pixel_rgb[3*p + 2] = rd_data.panel[p].blue[pixel_plane];
        end
    end

endmodule

/* source/multimem.sv */
/*
 * banked framebuffer RAM
 * a host byte goes to the single lane picked by {panel, colour};
 * a read fetches one body address from all lanes in parallel
 */
`timescale 1ns/1ns

module multimem #(
    parameter int unsigned ADDR_BITS = fb_geom_pkg::BODY_BITS,
    parameter int unsigned DW = fb_geom_pkg::BYTE_W
) (
    input  logic                         ClockA,
    input  logic                         arst_n,
    input  logic                         wr_en,
    input  fb_types_pkg::mem_write_addr_t wr_addr,
    input  logic [DW-1:0]                wr_data,
    input  logic                         rd_en,
    input  fb_types_pkg::mem_read_addr_t  rd_addr,
    output fb_types_pkg::mem_read_data_u  rd_data
);
    import fb_geom_pkg::*;

    localparam int unsigned LANE_BITS = PANEL_BITS + COLOR_BITS;

    // lane number = panel * 4 + colour
    logic [LANE_BITS-1:0] lane_sel_w;
    logic [DW-1:0]        lane_dob_w [LANES];

    assign lane_sel_w = {wr_addr.panel, wr_addr.color};

    for (genvar i = 0; i < LANES; i++) begin : g_lane
        logic                 we_q;
        logic [ADDR_BITS-1:0] addra_q;
        logic [DW-1:0]        dia_q;

        // each lane keeps its own copy of the write request
        always_ff @(posedge ClockA or negedge arst_n) begin
            if (!arst_n) begin
                we_q <= 1'b0;
            end else begin
                we_q <= wr_en && (lane_sel_w == LANE_BITS'(i));
            end
        end

        // body address and byte, written one edge later
        always_ff @(posedge ClockA) begin
            addra_q <= {wr_addr.row, wr_addr.col};
            dia_q   <= wr_data;
        end

        mem_lane #(
            .ADDR_BITS(ADDR_BITS),
            .DW       (DW)
        ) u_lane (
            .ClockA(ClockA),
            .arst_n(arst_n),
            .wea   (we_q),
            .addra (addra_q),
            .dia   (dia_q),
            .enb   (rd_en),
            .addrb (rd_addr),
            .dob   (lane_dob_w[i])
        );
    end

    // pack the lanes into the wide word, lane L at bit 8L
    always_comb begin
        for (int l = 0; l < LANES; l++) begin
            rd_data.lane[l] = lane_dob_w[l];
        end
    end

endmodule

/* source/mem_lane.sv */
/*
 * framebuffer lane RAM
 * simple dual-port byte memory, synchronous write on port a,
 * two-cycle registered read on port b
 */
`timescale 1ns/1ns

module mem_lane #(
    parameter int unsigned ADDR_BITS = 6,
    parameter int unsigned DW = 8
) (
    input  logic                 ClockA,
    input  logic                 arst_n,
    input  logic                 wea,
    input  logic [ADDR_BITS-1:0] addra,
    input  logic [DW-1:0]        dia,
    input  logic                 enb,
    input  logic [ADDR_BITS-1:0] addrb,
    output logic [DW-1:0]        dob
);

    logic [DW-1:0]        mem [2**ADDR_BITS];
    logic [ADDR_BITS-1:0] addrb_q;
    logic                 enb_q;

    // write port, no reset on the array
    always_ff @(posedge ClockA) begin
        if (wea) begin
            mem[addra] <= dia;
        end
    end

    // read stage 1 captures the address, stage 2 the data
    always_ff @(posedge ClockA or negedge arst_n) begin
        if (!arst_n) begin
            addrb_q <= '0;
            enb_q   <= 1'b0;
            dob     <= '0;
        end else begin
            enb_q <= enb;
            if (enb) begin
                addrb_q <= addrb;
            end
            // output only moves for a real read
            if (enb_q) begin
                dob <= mem[addrb_q];
            end
        end
    end

endmodule

/* source/fb_types_pkg.sv */
/*
 * framebuffer bus types
 * host write address, scan read address, wide read word and pixel bit vector
 */
package fb_types_pkg;

    // host write address, msb first: panel, row, col, colour
    typedef struct packed {
        logic [fb_geom_pkg::PANEL_BITS-1:0] panel;
        logic [fb_geom_pkg::ROW_BITS-1:0]   row;
        logic [fb_geom_pkg::COL_BITS-1:0]   col;
        logic [fb_geom_pkg::COLOR_BITS-1:0] color;
    } mem_write_addr_t;

    // body address {row, col}, same for every lane
    typedef logic [fb_geom_pkg::BODY_BITS-1:0] mem_read_addr_t;

    // the four lanes of one panel, red sits lowest (colour 0)
    typedef struct packed {
        logic [fb_geom_pkg::BYTE_W-1:0] spare;
        logic [fb_geom_pkg::BYTE_W-1:0] blue;
        logic [fb_geom_pkg::BYTE_W-1:0] green;
        logic [fb_geom_pkg::BYTE_W-1:0] red;
    } panel_bytes_t;

    // one read returns every lane at once
    // lane L sits at bit 8L in both views
    typedef union packed {
        logic [fb_geom_pkg::LANES-1:0][fb_geom_pkg::BYTE_W-1:0] lane;
        panel_bytes_t [fb_geom_pkg::PANELS-1:0]                panel;
    } mem_read_data_u;

    // per panel p: bit 3p red, 3p+1 green, 3p+2 blue
    typedef logic [3*fb_geom_pkg::PANELS-1:0] rgb_bits_t;

endpackage

/* source/fb_geom_pkg.sv */
/*
 * framebuffer geometry
 * panel, colour select, body address and bit-plane sizes shared by the design
 */
package fb_geom_pkg;

    // panel select, 4 panels
    localparam int unsigned PANEL_BITS = 2;
    localparam int unsigned PANELS = 1 << PANEL_BITS;

    // colour select: 0 red, 1 green, 2 blue, 3 spare
    localparam int unsigned COLOR_BITS = 2;

    // body address split into row and column
    localparam int unsigned ROW_BITS = 3;
    localparam int unsigned COL_BITS = 3;

    // one colour byte per pixel
    localparam int unsigned BYTE_W = 8;

    // one lane per (panel, colour) pair
    localparam int unsigned LANES = 1 << (PANEL_BITS + COLOR_BITS);

    // row and column together address one lane
    localparam int unsigned BODY_BITS = ROW_BITS + COL_BITS;

    // 8 bit planes for binary-coded modulation
    localparam int unsigned PLANE_BITS = 3;

endpackage
